// File: Makefile
# Verilator build and run for the convolution core testbench

SIM := obj_dir/Vconv_core_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "sim passed" sim.log
	@! grep -q "sim failed" sim.log

$(SIM): filelist.f $(wildcard hw/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing -Wno-fatal --top-module conv_core_tb -f filelist.f

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
hw/accel_cfg_pkg.sv
hw/accel_types_pkg.sv
hw/route_sram.sv
hw/input_router.sv
hw/weight_router.sv
hw/pe_column.sv
hw/output_router.sv
hw/route_controller.sv
hw/conv_core_top.sv
sim/conv_core_tb.sv

// File: hw/accel_cfg_pkg.sv
/* Accelerator configuration
   Widths, element counts, SRAM select codes and pipeline drain depth */

package accel_cfg_pkg;

    // Datapath widths
    localparam int DATA_WIDTH      = 8;
    localparam int SRAM_DATA_WIDTH = 64;
    localparam int ADDR_WIDTH      = 8;
    localparam int PSUM_WIDTH      = 16;

    // One processing element per byte of an input word
    localparam int ROUTER_COUNT = 8;

    // Host SRAM select codes with 2 and 3 left unused
    localparam logic [1:0] WEIGHT_SRAM = 2'd0;
    localparam logic [1:0] INPUT_SRAM  = 2'd1;

    // Cycles from last step issue to last accumulate
    localparam int PIPE_DRAIN = 2;

endpackage : accel_cfg_pkg

// File: hw/accel_types_pkg.sv
/* Accelerator datapath types
   Bytes, addresses, SRAM words and partial-sum vectors shared by the stages */

package accel_types_pkg;

    import accel_cfg_pkg::*;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic [SRAM_DATA_WIDTH-1:0]   sram_word_t;

    // Lane 0 sits in the low byte of a stored word
    typedef data_t [ROUTER_COUNT-1:0]                  ifmap_word_t;
    typedef data_t [SRAM_DATA_WIDTH/DATA_WIDTH-1:0]    weight_word_t;

    // Element 0 first as seen by the PE column
    typedef data_t [0:ROUTER_COUNT-1] ifmap_vec_t;
    typedef psum_t [0:ROUTER_COUNT-1] psum_vec_t;

endpackage : accel_types_pkg

// File: hw/conv_core_top.sv
/* Convolution core datapath
   Host SRAM write decode plus router, PE column and output stages */

`timescale 1ns/1ps

module conv_core_top
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_reg_clear,
    input  sram_word_t i_data_in,
    input  addr_t      i_write_addr,
    input  logic [1:0] i_sram_select,
    input  logic       i_write_en,
    input  logic       i_route_en,
    input  addr_t      i_i_start_addr,
    input  addr_t      i_stride,
    input  addr_t      i_w_start_addr,
    input  addr_t      i_route_size,
    output psum_t      o_psum,
    output logic       o_psum_valid,
    output logic       o_done,
    output logic       o_busy
);

    logic       w_sram_we, ifmap_sram_we;
    logic       ctl_start, step_en, out_start;
    logic       ifmap_valid, weight_valid;
    ifmap_vec_t ifmap;
    data_t      weight;
    psum_vec_t  psum;

    // Unused select codes write nowhere
    always_comb begin
        w_sram_we     = 1'b0;
        ifmap_sram_we = 1'b0;
        case (i_sram_select)
            WEIGHT_SRAM: w_sram_we     = i_write_en;
            INPUT_SRAM:  ifmap_sram_we = i_write_en;
            default:     ;
        endcase
    end

    route_controller u_route_controller (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_reg_clear  (i_reg_clear),
        .i_route_en   (i_route_en),
        .i_route_size (i_route_size),
        .i_out_done   (o_done),
        .o_start      (ctl_start),
        .o_step_en    (step_en),
        .o_out_start  (out_start),
        .o_busy       (o_busy)
    );

    input_router u_input_router (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_reg_clear  (i_reg_clear),
        .i_sram_we    (ifmap_sram_we),
        .i_write_addr (i_write_addr),
        .i_data_in    (i_data_in),
        .i_start      (ctl_start),
        .i_start_addr (i_i_start_addr),
        .i_stride     (i_stride),
        .i_step_en    (step_en),
        .o_ifmap      (ifmap),
        .o_lane_valid (ifmap_valid)
    );

    weight_router u_weight_router (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_reg_clear  (i_reg_clear),
        .i_sram_we    (w_sram_we),
        .i_write_addr (i_write_addr),
        .i_data_in    (i_data_in),
        .i_start      (ctl_start),
        .i_start_addr (i_w_start_addr),
        .i_step_en    (step_en),
        .o_weight     (weight),
        .o_lane_valid (weight_valid)
    );

    // Each run starts from zeroed accumulators
    pe_column u_pe_column (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_clear        (i_reg_clear || ctl_start),
        .i_ifmap        (ifmap),
        .i_ifmap_valid  (ifmap_valid),
        .i_weight       (weight),
        .i_weight_valid (weight_valid),
        .o_psum         (psum)
    );

    output_router u_output_router (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_reg_clear  (i_reg_clear),
        .i_out_start  (out_start),
        .i_psum       (psum),
        .o_psum       (o_psum),
        .o_psum_valid (o_psum_valid),
        .o_done       (o_done)
    );

    // Host may only load the SRAMs while the core is idle
    a_no_write_busy : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_write_en && o_busy)
    ) else $error("SRAM write while busy");

endmodule : conv_core_top

// File: hw/input_router.sv
/* Input-feature router
   Reads ifmap words at strided addresses and hands one byte to each PE */

`timescale 1ns/1ps

module input_router
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_reg_clear,
    input  logic       i_sram_we,
    input  addr_t      i_write_addr,
    input  sram_word_t i_data_in,
    input  logic       i_start,
    input  addr_t      i_start_addr,
    input  addr_t      i_stride,
    input  logic       i_step_en,
    output ifmap_vec_t o_ifmap,
    output logic       o_lane_valid
);

    addr_t       rd_addr;
    addr_t       stride_q;
    logic        step_d1;
    ifmap_word_t rd_word;

    route_sram #(
        .word_t (ifmap_word_t),
        .DEPTH  (2**ADDR_WIDTH)
    ) u_ifmap_sram (
        .i_clk   (i_clk),
        .i_we    (i_sram_we),
        .i_waddr (i_write_addr),
        .i_wdata (ifmap_word_t'(i_data_in)),
        .i_re    (i_step_en),
        .i_raddr (rd_addr),
        .o_rdata (rd_word)
    );

    // Address walk wraps modulo the SRAM depth
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_addr      <= '0;
            stride_q     <= '0;
            step_d1      <= 1'b0;
            o_lane_valid <= 1'b0;
        end else if (i_reg_clear) begin
            step_d1      <= 1'b0;
            o_lane_valid <= 1'b0;
        end else begin
            if (i_start) begin
                rd_addr  <= i_start_addr;
                stride_q <= i_stride;
            end else if (i_step_en) begin
                rd_addr <= rd_addr + stride_q;
            end
            // Valid follows the SRAM read latency
            step_d1      <= i_step_en;
            o_lane_valid <= step_d1;
        end
    end

    // Lane j of the word goes to PE j
    always_ff @(posedge i_clk) begin
        if (step_d1) begin
            for (int j = 0; j < ROUTER_COUNT; j++) begin
                o_ifmap[j] <= rd_word[j];
            end
        end
    end

endmodule : input_router

// File: hw/output_router.sv
/* Output router
   Latches the psum vector and streams it out one element per cycle */

`timescale 1ns/1ps

module output_router
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_reg_clear,
    input  logic      i_out_start,
    input  psum_vec_t i_psum,
    output psum_t     o_psum,
    output logic      o_psum_valid,
    output logic      o_done
);

    psum_vec_t                         shift_q;
    logic                              active;
    logic [$clog2(ROUTER_COUNT)-1:0]   beat_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (i_reg_clear) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (i_out_start) begin
            active   <= 1'b1;
            beat_cnt <= '0;
        end else if (active) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (o_done) begin
                active <= 1'b0;
            end
        end
    end

    // Element 0 leaves first
    always_ff @(posedge i_clk) begin
        if (i_out_start) begin
            shift_q <= i_psum;
        end else if (active) begin
            shift_q <= {shift_q[1:ROUTER_COUNT-1], psum_t'(0)};
        end
    end

    assign o_psum       = shift_q[0];
    assign o_psum_valid = active;
    assign o_done       = active && (beat_cnt == ROUTER_COUNT - 1);

    // Controller only starts a new drain once the previous one finished
    a_no_restart : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_out_start |-> !active
    ) else $error("output start during serialization");

endmodule : output_router

// File: hw/pe_column.sv
/* PE column
   Eight signed 8x8 multipliers feeding wrapping 16-bit accumulators */

`timescale 1ns/1ps

module pe_column
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  ifmap_vec_t i_ifmap,
    input  logic       i_ifmap_valid,
    input  data_t      i_weight,
    input  logic       i_weight_valid,
    output psum_vec_t  o_psum
);

    logic acc_en;

    assign acc_en = i_ifmap_valid && i_weight_valid;

    for (genvar j = 0; j < ROUTER_COUNT; j++) begin : g_pe
        psum_t prod;

        // Full product fits in 16 bits, so only the sum wraps
        assign prod = i_weight * i_ifmap[j];

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                o_psum[j] <= '0;
            end else if (i_clear) begin
                o_psum[j] <= '0;
            end else if (acc_en) begin
                o_psum[j] <= o_psum[j] + prod;
            end
        end
    end

    // Both routers share one pipeline depth, so their lanes land together
    a_valid_aligned : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_weight_valid == i_ifmap_valid
    ) else $error("weight and ifmap valids disagree");

endmodule : pe_column

// File: hw/route_controller.sv
/* Route controller
   Issues the routing steps, waits out the pipeline and hands off to output */

`timescale 1ns/1ps

module route_controller
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_reg_clear,
    input  logic  i_route_en,
    input  addr_t i_route_size,
    input  logic  i_out_done,
    output logic  o_start,
    output logic  o_step_en,
    output logic  o_out_start,
    output logic  o_busy
);

    typedef enum logic [1:0] {ST_IDLE, ST_STEP, ST_DRAIN, ST_OUT} state_t;

    state_t state;
    addr_t  cnt;
    addr_t  size_q;

    // Shared counter counts steps first and then drain cycles
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            size_q      <= '0;
            o_out_start <= 1'b0;
        end else if (i_reg_clear) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            o_out_start <= 1'b0;
        end else begin
            o_out_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_route_en) begin
                        size_q <= i_route_size;
                        cnt    <= '0;
                        state  <= ST_STEP;
                    end
                end
                ST_STEP: begin
                    if (cnt == size_q - addr_t'(1)) begin
                        cnt   <= '0;
                        state <= ST_DRAIN;
                    end else begin
                        cnt <= cnt + addr_t'(1);
                    end
                end
                ST_DRAIN: begin
                    if (cnt == addr_t'(PIPE_DRAIN - 1)) begin
                        o_out_start <= 1'b1;
                        state       <= ST_OUT;
                    end else begin
                        cnt <= cnt + addr_t'(1);
                    end
                end
                default: begin
                    if (i_out_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Start also clears the accumulators at the top level
    assign o_start   = (state == ST_IDLE) && i_route_en;
    assign o_step_en = (state == ST_STEP);
    assign o_busy    = (state != ST_IDLE);

    a_size_nonzero : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_route_en |-> (i_route_size != '0)
    ) else $error("route started with size 0");

endmodule : route_controller

// File: hw/route_sram.sv
/* Router SRAM
   One write port and one registered read port, generic over the stored word */

`timescale 1ns/1ps

module route_sram
    import accel_types_pkg::*;
#(
    parameter type word_t = sram_word_t,
    parameter int  DEPTH  = 2**$bits(addr_t)
) (
    input  logic  i_clk,
    input  logic  i_we,
    input  addr_t i_waddr,
    input  word_t i_wdata,
    input  logic  i_re,
    input  addr_t i_raddr,
    output word_t o_rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // Read data holds between read strobes
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule : route_sram

// File: hw/weight_router.sv
/* Weight router
   Walks the weight SRAM byte by byte and broadcasts one weight per step */

`timescale 1ns/1ps

module weight_router
    import accel_cfg_pkg::*, accel_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_reg_clear,
    input  logic       i_sram_we,
    input  addr_t      i_write_addr,
    input  sram_word_t i_data_in,
    input  logic       i_start,
    input  addr_t      i_start_addr,
    input  logic       i_step_en,
    output data_t      o_weight,
    output logic       o_lane_valid
);

    addr_t        w_base;
    addr_t        byte_cnt;
    addr_t        rd_addr;
    logic         step_d1;
    weight_word_t rd_word;
    logic [$clog2(SRAM_DATA_WIDTH/DATA_WIDTH)-1:0] lane_sel;
    logic [$clog2(SRAM_DATA_WIDTH/DATA_WIDTH)-1:0] lane_d1;

    // Upper counter bits pick the word, lower bits the byte
    assign lane_sel = byte_cnt[$bits(lane_sel)-1:0];
    assign rd_addr  = w_base + (byte_cnt >> $bits(lane_sel));

    route_sram #(
        .word_t (weight_word_t),
        .DEPTH  (2**ADDR_WIDTH)
    ) u_weight_sram (
        .i_clk   (i_clk),
        .i_we    (i_sram_we),
        .i_waddr (i_write_addr),
        .i_wdata (weight_word_t'(i_data_in)),
        .i_re    (i_step_en),
        .i_raddr (rd_addr),
        .o_rdata (rd_word)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            w_base       <= '0;
            byte_cnt     <= '0;
            lane_d1      <= '0;
            step_d1      <= 1'b0;
            o_lane_valid <= 1'b0;
        end else if (i_reg_clear) begin
            step_d1      <= 1'b0;
            o_lane_valid <= 1'b0;
        end else begin
            if (i_start) begin
                w_base   <= i_start_addr;
                byte_cnt <= '0;
            end else if (i_step_en) begin
                byte_cnt <= byte_cnt + addr_t'(1);
            end
            // Lane select rides along with the read
            lane_d1      <= lane_sel;
            step_d1      <= i_step_en;
            o_lane_valid <= step_d1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (step_d1) begin
            o_weight <= rd_word[lane_d1];
        end
    end

endmodule : weight_router

// File: sim/conv_core_tb.sv
/* Convolution core testbench
   Directed runs checked against a reference model of the step rule */

`timescale 1ns/1ps

module conv_core_tb
    import accel_cfg_pkg::*, accel_types_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int TEST_COUNT   = 6;
    // Route steps and host writes summed over all tests
    localparam int TOTAL_STEPS  = 72;
    localparam int TOTAL_WRITES = 76;
    // Extra room per test for latency, beats and idle windows
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS + TOTAL_WRITES + 60 * TEST_COUNT;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_reg_clear;
    sram_word_t i_data_in;
    addr_t      i_write_addr;
    logic [1:0] i_sram_select;
    logic       i_write_en;
    logic       i_route_en;
    addr_t      i_i_start_addr;
    addr_t      i_stride;
    addr_t      i_w_start_addr;
    addr_t      i_route_size;
    psum_t      o_psum;
    logic       o_psum_valid;
    logic       o_done;
    logic       o_busy;

    // Mirrors of both SRAMs and the expected sums of one run
    sram_word_t wmem_m [256];
    sram_word_t imem_m [256];
    psum_t      exp_psum [ROUTER_COUNT];

    integer seed = 32'h16a0;
    int     mismatch_count = 0;
    int     fail_count = 0;

    conv_core_top u_conv_core_top (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_reg_clear    (i_reg_clear),
        .i_data_in      (i_data_in),
        .i_write_addr   (i_write_addr),
        .i_sram_select  (i_sram_select),
        .i_write_en     (i_write_en),
        .i_route_en     (i_route_en),
        .i_i_start_addr (i_i_start_addr),
        .i_stride       (i_stride),
        .i_w_start_addr (i_w_start_addr),
        .i_route_size   (i_route_size),
        .o_psum         (o_psum),
        .o_psum_valid   (o_psum_valid),
        .o_done         (o_done),
        .o_busy         (o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    function automatic sram_word_t rand_word();
        sram_word_t w;
        w[31:0]  = $random(seed);
        w[63:32] = $random(seed);
        return w;
    endfunction

    task automatic check_psum(input psum_t got, input psum_t exp, input int index);
        if (got !== exp) begin
            $display("mismatch o_psum[%0d]: got %h expected %h", index, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    // Mirror is updated only for the two live select codes
    task automatic write_word(input logic [1:0] sel, input addr_t addr, input sram_word_t data);
        @(negedge i_clk);
        i_sram_select = sel;
        i_write_addr  = addr;
        i_data_in     = data;
        i_write_en    = 1'b1;
        if (sel == WEIGHT_SRAM) begin
            wmem_m[addr] = data;
        end else if (sel == INPUT_SRAM) begin
            imem_m[addr] = data;
        end
    endtask

    task automatic load_run_data(input addr_t istart, input addr_t stride,
                                 input addr_t wstart, input addr_t size);
        int n_words;
        n_words = (int'(size) + 7) / 8;
        for (int w = 0; w < n_words; w++) begin
            write_word(WEIGHT_SRAM, wstart + addr_t'(w), rand_word());
        end
        for (int k = 0; k < int'(size); k++) begin
            write_word(INPUT_SRAM, istart + addr_t'(k * int'(stride)), rand_word());
        end
    endtask

    // Step k weight is lane k mod 8 of word wstart + k div 8
    // Input word for step k sits at istart + k*stride
    task automatic compute_expected(input addr_t istart, input addr_t stride,
                                    input addr_t wstart, input addr_t size);
        addr_t ia;
        addr_t wa;
        data_t w;
        data_t x;
        psum_t p;
        for (int j = 0; j < ROUTER_COUNT; j++) begin
            exp_psum[j] = '0;
        end
        for (int k = 0; k < int'(size); k++) begin
            wa = wstart + addr_t'(k / 8);
            ia = istart + addr_t'(k * int'(stride));
            w  = data_t'(wmem_m[wa] >> (8 * (k % 8)));
            for (int j = 0; j < ROUTER_COUNT; j++) begin
                x = data_t'(imem_m[ia] >> (8 * j));
                p = psum_t'(w) * psum_t'(x);
                exp_psum[j] = exp_psum[j] + p;
            end
        end
    endtask

    task automatic start_run(input addr_t istart, input addr_t stride,
                             input addr_t wstart, input addr_t size);
        @(negedge i_clk);
        i_write_en     = 1'b0;
        i_i_start_addr = istart;
        i_stride       = stride;
        i_w_start_addr = wstart;
        i_route_size   = size;
        i_route_en     = 1'b1;
        @(negedge i_clk);
        i_route_en = 1'b0;
        check_flag("o_busy", o_busy, 1'b1);
    endtask

    // Waits for the first beat, then expects eight in a row
    task automatic collect_beats(input addr_t size);
        int wait_cnt;
        wait_cnt = 0;
        while (!o_psum_valid && wait_cnt < int'(size) + PIPE_DRAIN + 10) begin
            @(negedge i_clk);
            wait_cnt++;
        end
        if (!o_psum_valid) begin
            $display("no output beat within %0d cycles of start", wait_cnt);
            fail_count++;
            return;
        end
        for (int b = 0; b < ROUTER_COUNT; b++) begin
            if (!o_psum_valid) begin
                $display("output beat %0d missing", b);
                fail_count++;
                return;
            end
            check_psum(o_psum, exp_psum[b], b);
            if (b == ROUTER_COUNT - 1) begin
                if (o_done !== 1'b1) begin
                    $display("done pulse missing on the last beat");
                    fail_count++;
                end
            end else begin
                check_flag("o_done", o_done, 1'b0);
            end
            @(negedge i_clk);
        end
        check_flag("o_psum_valid", o_psum_valid, 1'b0);
        check_flag("o_busy", o_busy, 1'b0);
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge i_clk);
            check_flag("o_busy", o_busy, 1'b0);
            check_flag("o_psum_valid", o_psum_valid, 1'b0);
            check_flag("o_done", o_done, 1'b0);
        end
    endtask

    task automatic single_step_run();
        load_run_data(8'h20, 8'd0, 8'h10, 8'd1);
        compute_expected(8'h20, 8'd0, 8'h10, 8'd1);
        start_run(8'h20, 8'd0, 8'h10, 8'd1);
        collect_beats(8'd1);
    endtask

    task automatic strided_run();
        addr_t a;
        load_run_data(8'hF0, 8'd3, 8'hFF, 8'd12);
        // All -128 weights against -128 in lane 0 push element 0 past 16 bits
        write_word(WEIGHT_SRAM, 8'hFF, {8{8'h80}});
        for (int k = 0; k < 12; k++) begin
            a = 8'hF0 + addr_t'(k * 3);
            write_word(INPUT_SRAM, a, {imem_m[a][63:8], 8'h80});
        end
        compute_expected(8'hF0, 8'd3, 8'hFF, 8'd12);
        start_run(8'hF0, 8'd3, 8'hFF, 8'd12);
        collect_beats(8'd12);
    endtask

    task automatic select_code_run();
        load_run_data(8'h40, 8'd1, 8'h30, 8'd8);
        // Codes 2 and 3 must not land in either SRAM
        write_word(2'd2, 8'h30, rand_word());
        write_word(2'd3, 8'h43, rand_word());
        compute_expected(8'h40, 8'd1, 8'h30, 8'd8);
        start_run(8'h40, 8'd1, 8'h30, 8'd8);
        collect_beats(8'd8);
    endtask

    task automatic back_to_back_runs();
        load_run_data(8'h60, 8'd2, 8'h50, 8'd6);
        compute_expected(8'h60, 8'd2, 8'h50, 8'd6);
        start_run(8'h60, 8'd2, 8'h50, 8'd6);
        repeat (2) @(negedge i_clk);
        // Second pulse lands while busy
        i_i_start_addr = 8'h00;
        i_route_size   = 8'd4;
        i_route_en     = 1'b1;
        @(negedge i_clk);
        i_route_en = 1'b0;
        collect_beats(8'd6);
        for (int c = 0; c < 12; c++) begin
            if (o_psum_valid || o_busy) begin
                $display("extra activity after done, ignored start was taken");
                fail_count++;
                break;
            end
            @(negedge i_clk);
        end
        load_run_data(8'h70, 8'd1, 8'h58, 8'd5);
        compute_expected(8'h70, 8'd1, 8'h58, 8'd5);
        start_run(8'h70, 8'd1, 8'h58, 8'd5);
        collect_beats(8'd5);
    endtask

    task automatic clear_mid_run();
        load_run_data(8'h80, 8'd5, 8'h90, 8'd20);
        start_run(8'h80, 8'd5, 8'h90, 8'd20);
        repeat (5) @(negedge i_clk);
        i_reg_clear = 1'b1;
        @(negedge i_clk);
        i_reg_clear = 1'b0;
        check_flag("o_busy", o_busy, 1'b0);
        for (int c = 0; c < 30; c++) begin
            if (o_psum_valid) begin
                $display("output beat seen after register clear");
                fail_count++;
                break;
            end
            @(negedge i_clk);
        end
        compute_expected(8'h80, 8'd5, 8'h90, 8'd20);
        start_run(8'h80, 8'd5, 8'h90, 8'd20);
        collect_beats(8'd20);
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_reg_clear    = 1'b0;
        i_data_in      = '0;
        i_write_addr   = '0;
        i_sram_select  = 2'd0;
        i_write_en     = 1'b0;
        i_route_en     = 1'b0;
        i_i_start_addr = '0;
        i_stride       = '0;
        i_w_start_addr = '0;
        i_route_size   = 8'd1;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        idle_after_reset();
        single_step_run();
        strided_run();
        select_code_run();
        back_to_back_runs();
        clear_mid_run();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count + fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : conv_core_tb
